// ==== design/mport_pkg.sv ====
package mport_pkg;

  // data and array geometry
  localparam int WORD_W   = 16;
  localparam int NUM_VBNK = 8;
  localparam int BANK_W   = 3;
  localparam int NUM_VROW = 64;
  localparam int ROW_W    = 6;
  localparam int ADDR_W   = BANK_W + ROW_W;

  localparam int NUM_RPORT = 2;

  // the bank array takes two cycles and the output register adds one
  localparam int SRAM_DELAY   = 2;
  localparam int READ_LATENCY = SRAM_DELAY + 1;

  typedef logic [WORD_W-1:0] word_t;

  // upper BANK_W bits select the bank, lower ROW_W bits the row
  typedef logic [ADDR_W-1:0] addr_t;

  typedef logic [ROW_W-1:0] row_t;
  typedef logic [BANK_W-1:0] bank_t;

  typedef enum logic {
    st_clear,
    st_run
  } init_state_t;

endpackage

// ==== design/bank_if.sv ====
`timescale 1ns/10ps

interface bank_if;
  import mport_pkg::*;

  logic  rd_en;
  row_t  rd_row;
  logic  wr_en;
  row_t  wr_row;
  word_t wr_data;
  word_t rd_data;

  // read requests come from the scheduler
  modport issue (output rd_en, output rd_row);

  // writes come from the write path, both init clear and normal writes
  modport fill (output wr_en, output wr_row, output wr_data);

  modport mem (
    input  rd_en, rd_row, wr_en, wr_row, wr_data,
    output rd_data
  );

  modport sink (input rd_data);

endinterface

// ==== design/sram_1r1w.sv ====
`timescale 1ns/10ps

module sram_1r1w (
  input logic clk,
  input logic rst,
  bank_if.mem port
);
  import mport_pkg::*;

  word_t mem [NUM_VROW];
  logic  rd_en_q;
  row_t  rd_row_q;

  // a write lands at the edge, so a read issued next cycle sees it
  always_ff @(posedge clk) begin
    if (port.wr_en) begin
      mem[port.wr_row] <= port.wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_en_q <= 1'b0;
    end else begin
      rd_en_q <= port.rd_en;
    end
  end

  // first stage holds the row, second stage holds the word
  always_ff @(posedge clk) begin
    if (port.rd_en) begin
      rd_row_q <= port.rd_row;
    end
    if (rd_en_q) begin
      port.rd_data <= mem[rd_row_q];
    end
  end

endmodule

// ==== design/read_scheduler.sv ====
`timescale 1ns/10ps

module read_scheduler (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              ready,
  input  logic [mport_pkg::NUM_RPORT-1:0]   read,
  input  mport_pkg::addr_t                  rd_adr0,
  input  mport_pkg::addr_t                  rd_adr1,
  input  logic                              write,
  input  mport_pkg::addr_t                  wr_adr,
  bank_if.issue                             bank_rd [mport_pkg::NUM_VBNK],
  bank_if.issue                             xor_rd,
  output logic                              conflict,
  output mport_pkg::row_t                   rd_row1
);
  import mport_pkg::*;

  bank_t rd_bank0;
  bank_t rd_bank1;
  bank_t wr_bank;
  row_t  rd_row0;
  row_t  wr_row;
  logic  rd0_go;
  logic  rd1_go;
  logic  wr_go;

  assign rd_bank0 = rd_adr0[ADDR_W-1 -: BANK_W];
  assign rd_bank1 = rd_adr1[ADDR_W-1 -: BANK_W];
  assign wr_bank  = wr_adr[ADDR_W-1 -: BANK_W];
  assign rd_row0  = rd_adr0[ROW_W-1:0];
  assign rd_row1  = rd_adr1[ROW_W-1:0];
  assign wr_row   = wr_adr[ROW_W-1:0];

  assign rd0_go = ready && read[0];
  assign rd1_go = ready && read[1];
  assign wr_go  = ready && write;

  assign conflict = rd0_go && rd1_go && (rd_bank0 == rd_bank1);

  for (genvar i = 0; i < NUM_VBNK; i++) begin : g_bank
    logic use0;
    logic use1;
    logic usew;

    assign use0 = rd0_go && (rd_bank0 == bank_t'(i));

    // on a conflict port 1 borrows every bank except its own
    assign use1 = conflict ? (rd_bank1 != bank_t'(i)) :
                             (rd1_go && (rd_bank1 == bank_t'(i)));

    // a write needs the other banks at its row to rebuild parity
    assign usew = wr_go && (wr_bank != bank_t'(i));

    assign bank_rd[i].rd_en  = use0 || use1 || usew;
    assign bank_rd[i].rd_row = use0 ? rd_row0 : (use1 ? rd_row1 : wr_row);
  end

  assign xor_rd.rd_en  = conflict;
  assign xor_rd.rd_row = rd_row1;

  // the parity reads of a write use the read ports of all banks
  a_no_rw_mix: assert property (@(posedge clk) disable iff (rst)
    ready |-> !(write && (|read)));

endmodule

// ==== design/write_path.sv ====
`timescale 1ns/10ps

module write_path (
  input  logic              clk,
  input  logic              rst,
  input  logic              write,
  input  mport_pkg::addr_t  wr_adr,
  input  mport_pkg::word_t  din,
  input  logic              conflict,
  input  mport_pkg::row_t   rd_row1,
  bank_if.sink              bank_rd_data [mport_pkg::NUM_VBNK],
  output logic              ready,
  bank_if.fill              bank_wr [mport_pkg::NUM_VBNK],
  bank_if.fill              xor_wr,
  output logic              fwd_hit,
  output mport_pkg::word_t  fwd_data
);
  import mport_pkg::*;

  init_state_t    state;
  logic [ROW_W:0] clr_cnt;
  logic           clearing;
  logic           wr_go;
  bank_t          wr_bank;
  row_t           wr_row;
  logic           p1_vld;
  logic           p2_vld;
  row_t           p1_row;
  row_t           p2_row;
  bank_t          p1_bank;
  bank_t          p2_bank;
  word_t          p1_din;
  word_t          p2_din;
  word_t          rd_word [NUM_VBNK];
  word_t          parity;
  logic           hit_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_clear;
      clr_cnt <= '0;
    end else if (state == st_clear) begin
      clr_cnt <= clr_cnt + 1'b1;
      if (clr_cnt == (ROW_W+1)'(NUM_VROW - 1)) begin
        state <= st_run;
      end
    end
  end

  assign clearing = (state == st_clear);
  assign ready    = (state == st_run);

  assign wr_go   = ready && write;
  assign wr_bank = wr_adr[ADDR_W-1 -: BANK_W];
  assign wr_row  = wr_adr[ROW_W-1:0];

  for (genvar i = 0; i < NUM_VBNK; i++) begin : g_bank
    assign rd_word[i] = bank_rd_data[i].rd_data;

    assign bank_wr[i].wr_en   = clearing || (wr_go && (wr_bank == bank_t'(i)));
    assign bank_wr[i].wr_row  = clearing ? clr_cnt[ROW_W-1:0] : wr_row;
    assign bank_wr[i].wr_data = clearing ? '0 : din;
  end

  // parity reads issued with the write come back two cycles later
  always_ff @(posedge clk) begin
    if (rst) begin
      p1_vld  <= 1'b0;
      p2_vld  <= 1'b0;
      hit_q   <= 1'b0;
      fwd_hit <= 1'b0;
    end else begin
      p1_vld  <= wr_go;
      p2_vld  <= p1_vld;
      hit_q   <= conflict && p1_vld && (rd_row1 == p1_row);
      fwd_hit <= hit_q;
    end
  end

  always_ff @(posedge clk) begin
    p1_row  <= wr_row;
    p1_bank <= wr_bank;
    p1_din  <= din;
    p2_row  <= p1_row;
    p2_bank <= p1_bank;
    p2_din  <= p1_din;
    if (p2_vld) begin
      fwd_data <= parity;
    end
  end

  // the old word of the target bank drops out, only din and the others count
  always_comb begin
    parity = p2_din;
    for (int i = 0; i < NUM_VBNK; i++) begin
      if (bank_t'(i) != p2_bank) begin
        parity = parity ^ rd_word[i];
      end
    end
  end

  // a conflict read one cycle after a write to its row misses this update
  assign xor_wr.wr_en   = clearing || p2_vld;
  assign xor_wr.wr_row  = clearing ? clr_cnt[ROW_W-1:0] : p2_row;
  assign xor_wr.wr_data = clearing ? '0 : parity;

  a_clear_row: assert property (@(posedge clk) disable iff (rst)
    (state == st_clear) |-> (clr_cnt < (ROW_W+1)'(NUM_VROW)));

endmodule

// ==== design/read_assembly.sv ====
`timescale 1ns/10ps

module read_assembly (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [mport_pkg::NUM_RPORT-1:0]  read,
  input  logic                             conflict,
  input  mport_pkg::bank_t                 rd_bank0,
  input  mport_pkg::bank_t                 rd_bank1,
  input  logic                             fwd_hit,
  input  mport_pkg::word_t                 fwd_data,
  bank_if.sink                             bank_rd [mport_pkg::NUM_VBNK],
  bank_if.sink                             xor_rd,
  output logic [mport_pkg::NUM_RPORT-1:0]  rd_vld,
  output mport_pkg::word_t                 rd_dout0,
  output mport_pkg::word_t                 rd_dout1
);
  import mport_pkg::*;

  logic [NUM_RPORT-1:0] vld_q [SRAM_DELAY];
  logic                 cflt_q [SRAM_DELAY];
  bank_t                bank0_q [SRAM_DELAY];
  bank_t                bank1_q [SRAM_DELAY];
  word_t                rd_word [NUM_VBNK];
  word_t                rebuilt;
  word_t                word0;
  word_t                word1;

  for (genvar i = 0; i < NUM_VBNK; i++) begin : g_word
    assign rd_word[i] = bank_rd[i].rd_data;
  end

  // tags follow the bank read so they line up with rd_data
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < SRAM_DELAY; s++) begin
        vld_q[s]  <= '0;
        cflt_q[s] <= 1'b0;
      end
    end else begin
      vld_q[0]  <= read;
      cflt_q[0] <= conflict;
      for (int s = 1; s < SRAM_DELAY; s++) begin
        vld_q[s]  <= vld_q[s-1];
        cflt_q[s] <= cflt_q[s-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    bank0_q[0] <= rd_bank0;
    bank1_q[0] <= rd_bank1;
    for (int s = 1; s < SRAM_DELAY; s++) begin
      bank0_q[s] <= bank0_q[s-1];
      bank1_q[s] <= bank1_q[s-1];
    end
  end

  // port 1 word rebuilt from the other banks and the parity row
  always_comb begin
    rebuilt = fwd_hit ? fwd_data : xor_rd.rd_data;
    for (int i = 0; i < NUM_VBNK; i++) begin
      if (bank_t'(i) != bank1_q[SRAM_DELAY-1]) begin
        rebuilt = rebuilt ^ rd_word[i];
      end
    end
  end

  assign word0 = rd_word[bank0_q[SRAM_DELAY-1]];
  assign word1 = cflt_q[SRAM_DELAY-1] ? rebuilt : rd_word[bank1_q[SRAM_DELAY-1]];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld <= '0;
    end else begin
      rd_vld <= vld_q[SRAM_DELAY-1];
    end
  end

  always_ff @(posedge clk) begin
    rd_dout0 <= word0;
    rd_dout1 <= word1;
  end

  // a same-bank pair that was not flagged as a conflict must not return on port 1
  a_cflt_flagged: assert property (@(posedge clk) disable iff (rst)
    ((&vld_q[SRAM_DELAY-1]) && (bank0_q[SRAM_DELAY-1] == bank1_q[SRAM_DELAY-1]) &&
     !cflt_q[SRAM_DELAY-1]) |=> !rd_vld[1]);

endmodule

// ==== design/mport_mem_2r1w.sv ====
`timescale 1ns/10ps

module mport_mem_2r1w (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [mport_pkg::NUM_RPORT-1:0]  read,
  input  mport_pkg::addr_t                 rd_adr0,
  input  mport_pkg::addr_t                 rd_adr1,
  input  logic                             write,
  input  mport_pkg::addr_t                 wr_adr,
  input  mport_pkg::word_t                 din,
  output logic                             ready,
  output logic [mport_pkg::NUM_RPORT-1:0]  rd_vld,
  output mport_pkg::word_t                 rd_dout0,
  output mport_pkg::word_t                 rd_dout1
);
  import mport_pkg::*;

  logic  conflict;
  row_t  rd_row1;
  logic  fwd_hit;
  word_t fwd_data;

  bank_if bank_bus [NUM_VBNK] ();
  bank_if xor_bus ();

  for (genvar i = 0; i < NUM_VBNK; i++) begin : g_bank
    sram_1r1w i_sram (
      .clk  (clk),
      .rst  (rst),
      .port (bank_bus[i].mem)
    );
  end

  sram_1r1w i_xor_sram (
    .clk  (clk),
    .rst  (rst),
    .port (xor_bus.mem)
  );

  read_scheduler i_read_scheduler (
    .clk      (clk),
    .rst      (rst),
    .ready    (ready),
    .read     (read),
    .rd_adr0  (rd_adr0),
    .rd_adr1  (rd_adr1),
    .write    (write),
    .wr_adr   (wr_adr),
    .bank_rd  (bank_bus),
    .xor_rd   (xor_bus),
    .conflict (conflict),
    .rd_row1  (rd_row1)
  );

  write_path i_write_path (
    .clk          (clk),
    .rst          (rst),
    .write        (write),
    .wr_adr       (wr_adr),
    .din          (din),
    .conflict     (conflict),
    .rd_row1      (rd_row1),
    .bank_rd_data (bank_bus),
    .ready        (ready),
    .bank_wr      (bank_bus),
    .xor_wr       (xor_bus),
    .fwd_hit      (fwd_hit),
    .fwd_data     (fwd_data)
  );

  // reads are ignored until init is done
  read_assembly i_read_assembly (
    .clk      (clk),
    .rst      (rst),
    .read     (read & {NUM_RPORT{ready}}),
    .conflict (conflict),
    .rd_bank0 (rd_adr0[ADDR_W-1 -: BANK_W]),
    .rd_bank1 (rd_adr1[ADDR_W-1 -: BANK_W]),
    .fwd_hit  (fwd_hit),
    .fwd_data (fwd_data),
    .bank_rd  (bank_bus),
    .xor_rd   (xor_bus),
    .rd_vld   (rd_vld),
    .rd_dout0 (rd_dout0),
    .rd_dout1 (rd_dout1)
  );

endmodule

// ==== tests/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int DEPTH = NUM_VBNK * NUM_VROW;

// reference copy of the memory, indexed by the full word address
word_t model_mem [DEPTH];

// fibonacci lfsr with taps 32 22 2 1
logic [31:0] lfsr_state = 32'h40ec_cbc1;

function automatic logic lfsr_step();
  logic fb;
  fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

// one lfsr step for every bit taken
function automatic logic [31:0] take_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_step()};
  end
  return v;
endfunction

// upper bits pick the bank, lower bits the row
function automatic addr_t make_addr(input bank_t b, input row_t r);
  return {b, r};
endfunction

function automatic addr_t pick_addr();
  bank_t b;
  row_t  r;
  b = bank_t'(take_bits(BANK_W));
  r = row_t'(take_bits(ROW_W));
  return make_addr(b, r);
endfunction

function automatic word_t new_word();
  return word_t'(take_bits(WORD_W));
endfunction

function automatic void store_word(input addr_t a, input word_t d);
  model_mem[a] = d;
endfunction

// the memory is all zero once init is done
function automatic void zero_model();
  for (int i = 0; i < DEPTH; i++) begin
    model_mem[i] = '0;
  end
endfunction

`endif

// ==== tests/tb_mport.sv ====
`timescale 1ns/10ps

module tb_mport;
  import mport_pkg::*;

  logic                 clk;
  logic                 rst;
  logic [NUM_RPORT-1:0] read;
  addr_t                rd_adr0;
  addr_t                rd_adr1;
  logic                 write;
  addr_t                wr_adr;
  word_t                din;
  logic                 ready;
  logic [NUM_RPORT-1:0] rd_vld;
  word_t                rd_dout0;
  word_t                rd_dout1;

  // expected words go out with each read and move along with it
  word_t exp0;
  word_t exp1;
  word_t exp_q0 [READ_LATENCY];
  word_t exp_q1 [READ_LATENCY];

  int cyc_cnt;
  int data_errs = 0;
  int strobe_errs = 0;
  int ready_errs = 0;
  int timeout_errs = 0;

  `include "tb_model.svh"

  mport_mem_2r1w i_mport_mem_2r1w (
    .clk      (clk),
    .rst      (rst),
    .read     (read),
    .rd_adr0  (rd_adr0),
    .rd_adr1  (rd_adr1),
    .write    (write),
    .wr_adr   (wr_adr),
    .din      (din),
    .ready    (ready),
    .rd_vld   (rd_vld),
    .rd_dout0 (rd_dout0),
    .rd_dout1 (rd_dout1)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    if (rst) begin
      cyc_cnt <= 0;
    end else begin
      cyc_cnt <= cyc_cnt + 1;
    end
  end

  always @(posedge clk) begin
    exp_q0[0] <= exp0;
    exp_q1[0] <= exp1;
    for (int s = 1; s < READ_LATENCY; s++) begin
      exp_q0[s] <= exp_q0[s-1];
      exp_q1[s] <= exp_q1[s-1];
    end
  end

  a_ready_late: assert property (@(posedge clk) disable iff (rst)
    ready |-> (cyc_cnt >= NUM_VROW))
    else begin
      ready_errs = ready_errs + 1;
      $display("** Error at %0t: ready high after %0d init cycles", $time, $sampled(cyc_cnt));
    end

  a_ready_stays: assert property (@(posedge clk) disable iff (rst) ready |=> ready)
    else begin
      ready_errs = ready_errs + 1;
      $display("** Error at %0t: ready dropped after init", $time);
    end

  a_vld0_latency: assert property (@(posedge clk) disable iff (rst)
    rd_vld[0] == $past(ready && read[0], READ_LATENCY))
    else begin
      strobe_errs = strobe_errs + 1;
      $display("** Error at %0t: rd_vld[0] is %b, off its read by the latency", $time,
               $sampled(rd_vld[0]));
    end

  a_vld1_latency: assert property (@(posedge clk) disable iff (rst)
    rd_vld[1] == $past(ready && read[1], READ_LATENCY))
    else begin
      strobe_errs = strobe_errs + 1;
      $display("** Error at %0t: rd_vld[1] is %b, off its read by the latency", $time,
               $sampled(rd_vld[1]));
    end

  a_dout0: assert property (@(posedge clk) disable iff (rst)
    rd_vld[0] |-> (rd_dout0 == exp_q0[READ_LATENCY-1]))
    else begin
      data_errs = data_errs + 1;
      $display("** Error at %0t: port 0 returned %h, expected %h", $time,
               $sampled(rd_dout0), $sampled(exp_q0[READ_LATENCY-1]));
    end

  a_dout1: assert property (@(posedge clk) disable iff (rst)
    rd_vld[1] |-> (rd_dout1 == exp_q1[READ_LATENCY-1]))
    else begin
      data_errs = data_errs + 1;
      $display("** Error at %0t: port 1 returned %h, expected %h", $time,
               $sampled(rd_dout1), $sampled(exp_q1[READ_LATENCY-1]));
    end

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      read  <= '0;
      write <= 1'b0;
    end
  endtask

  task automatic write_word(input addr_t a, input word_t d);
    @(posedge clk);
    read   <= '0;
    write  <= 1'b1;
    wr_adr <= a;
    din    <= d;
    store_word(a, d);
  endtask

  task automatic read_words(input logic [NUM_RPORT-1:0] en, input addr_t a0, input addr_t a1);
    @(posedge clk);
    write   <= 1'b0;
    read    <= en;
    rd_adr0 <= a0;
    rd_adr1 <= a1;
    exp0    <= model_mem[a0];
    exp1    <= model_mem[a1];
  endtask

  // traffic in the first half of init has to be dropped by the DUT
  task automatic wait_ready();
    int n;
    n = 0;
    while (!ready && n < 4 * NUM_VROW) begin
      @(posedge clk);
      n++;
      if (n < NUM_VROW / 2 && n % 2 == 1) begin
        read   <= '0;
        write  <= 1'b1;
        wr_adr <= addr_t'(n * 13);
        din    <= word_t'(32'h8000 | n);
      end else if (n < NUM_VROW / 2) begin
        write   <= 1'b0;
        read    <= 2'b11;
        rd_adr0 <= addr_t'(n);
        rd_adr1 <= addr_t'(n + NUM_VROW);
      end else begin
        read  <= '0;
        write <= 1'b0;
      end
    end
    if (!ready) begin
      timeout_errs = timeout_errs + 1;
      $display("timeout: ready stayed low after reset");
    end
  endtask

  task automatic drain_reads();
    int quiet;
    int n;
    quiet = 0;
    n = 0;
    while (quiet <= READ_LATENCY && n < 32) begin
      @(posedge clk);
      read  <= '0;
      write <= 1'b0;
      n++;
      if (rd_vld == '0) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
    if (quiet <= READ_LATENCY) begin
      timeout_errs = timeout_errs + 1;
      $display("timeout: read strobes kept coming after the last read");
    end
  endtask

  task automatic cleared_reads();
    for (int i = 0; i < DEPTH / 2; i++) begin
      read_words(2'b11, addr_t'(2 * i), addr_t'(2 * i + 1));
    end
    for (int i = 0; i < DEPTH / 2; i++) begin
      read_words(2'b11, addr_t'(i), addr_t'(DEPTH - 1 - i));
    end
  endtask

  task automatic write_read_pairs();
    addr_t a;
    for (int i = 0; i < 8; i++) begin
      a = pick_addr();
      write_word(a, new_word());
      read_words(2'b01, a, '0);
      a = pick_addr();
      write_word(a, new_word());
      idle_cycles(1);
      read_words(2'b10, '0, a);
    end
  endtask

  task automatic fill_memory();
    for (int i = 0; i < DEPTH; i++) begin
      write_word(addr_t'(i), new_word());
    end
  endtask

  task automatic split_bank_reads();
    bank_t b0;
    bank_t off;
    for (int i = 0; i < 64; i++) begin
      b0  = bank_t'(take_bits(BANK_W));
      off = bank_t'(take_bits(BANK_W));
      if (off == '0) begin
        off = 1;
      end
      read_words(2'b11, make_addr(b0, row_t'(take_bits(ROW_W))),
                 make_addr(b0 ^ off, row_t'(take_bits(ROW_W))));
    end
  endtask

  task automatic same_bank_reads();
    bank_t b;
    addr_t a;
    for (int i = 0; i < 64; i++) begin
      b = bank_t'(take_bits(BANK_W));
      read_words(2'b11, make_addr(b, row_t'(take_bits(ROW_W))),
                 make_addr(b, row_t'(take_bits(ROW_W))));
    end
    a = pick_addr();
    read_words(2'b11, a, a);
  endtask

  // port 1 rebuilds from parity that is still in flight
  task automatic forwarding_reads();
    bank_t b;
    bank_t rb;
    row_t  r;
    for (int gap = 0; gap < 3; gap++) begin
      for (int tgt = 0; tgt < 2; tgt++) begin
        for (int k = 0; k < 4; k++) begin
          b = bank_t'(take_bits(BANK_W));
          r = row_t'(take_bits(ROW_W));
          write_word(make_addr(b, r), new_word());
          idle_cycles(gap);
          rb = (tgt == 0) ? b : bank_t'(b + 1);
          read_words(2'b11, make_addr(rb, row_t'(r + 1)), make_addr(rb, r));
        end
      end
    end
  endtask

  // few rows are used so that writes and conflict reads meet often
  task automatic random_traffic();
    int    op;
    bank_t b0;
    bank_t b1;
    row_t  r0;
    row_t  r1;
    for (int i = 0; i < 400; i++) begin
      op = int'(take_bits(3));
      b0 = bank_t'(take_bits(BANK_W));
      b1 = bank_t'(take_bits(BANK_W));
      r0 = row_t'(take_bits(2));
      r1 = row_t'(take_bits(2));
      case (op)
        0, 1, 2: write_word(make_addr(b0, r0), new_word());
        3: begin
          if (take_bits(1) == 32'd1) begin
            read_words(2'b10, make_addr(b0, r0), make_addr(b1, r1));
          end else begin
            read_words(2'b01, make_addr(b0, r0), make_addr(b1, r1));
          end
        end
        4, 5: read_words(2'b11, make_addr(b0, r0), make_addr(b1, r1));
        default: read_words(2'b11, make_addr(b0, r0), make_addr(b0, r1));
      endcase
    end
  endtask

  initial begin
    rst     <= 1'b1;
    read    <= '0;
    rd_adr0 <= '0;
    rd_adr1 <= '0;
    write   <= 1'b0;
    wr_adr  <= '0;
    din     <= '0;
    exp0    <= '0;
    exp1    <= '0;
    zero_model();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    wait_ready();
    if (timeout_errs == 0) begin
      cleared_reads();
      write_read_pairs();
      fill_memory();
      split_bank_reads();
      same_bank_reads();
      forwarding_reads();
      random_traffic();
      drain_reads();
    end
    $display("errors: data %0d, strobe %0d, ready %0d, timeout %0d",
             data_errs, strobe_errs, ready_errs, timeout_errs);
    if (data_errs + strobe_errs + ready_errs + timeout_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+tests
design/mport_pkg.sv
design/bank_if.sv
design/sram_1r1w.sv
design/read_scheduler.sv
design/write_path.sv
design/read_assembly.sv
design/mport_mem_2r1w.sv
tests/tb_mport.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log

set -u

cd "$(dirname "$0")" || exit 1

top="tb_mport"
log_file="sim.log"

verilator --binary --timing --assert --top-module "$top" -f files.f -o "sim_$top"
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

"./obj_dir/sim_$top" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "test passed" "$log_file"; then
  echo "log check: pass"
  exit 0
fi
echo "log check: fail"
exit 1
